// ==== Makefile ====
# Verilator flow for the vector execution unit
RTL := source/vfu_pkg.sv source/vfu_spill_reg.sv source/vfu_lane.sv \
       source/vfu_controller.sv source/vfu_writeback.sv source/vfu_top.sv

.PHONY: all lint sim clean

all: sim

# Lint the design only, with all warnings on
lint:
	verilator --lint-only -Wall --top-module vfu_top $(RTL)

# Build and run the testbench, the log decides pass or fail
sim:
	verilator --binary --timing --assert -j 0 --top-module tb_top -f sim.f -o tb_top
	./obj_dir/tb_top | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_top.sv ====
`timescale 1ns/1ps
// Testbench top for the vector execution unit
// VRF model reads combinationally and takes writes on the rising edge
// Stalls on rvalid and wvalid come from a Galois LFSR when enabled
// Sources use vregs 0 to 15 and results go to vregs 16 to 31

module tb_top;

  import vfu_pkg::*;

  localparam logic [31:0] SEED         = 32'h9a258cbf;
  localparam int          REQ_TIMEOUT  = 1000;
  localparam int          IDLE_TIMEOUT = 5000;
  localparam int          N_RANDOM     = 40;

  logic                   clk;
  logic                   rst_n;
  vfu_req_t               req;
  logic                   req_valid;
  logic                   req_ready;
  vreg_addr_t       [1:0] vrf_raddr;
  logic             [1:0] vrf_re;
  vreg_data_t       [1:0] vrf_rdata;
  logic             [1:0] vrf_rvalid;
  logic                   vrf_we;
  vreg_addr_t             vrf_waddr;
  vreg_data_t             vrf_wdata;
  logic                   vrf_wvalid;
  logic                   rsp_valid;
  vfu_id_t                rsp_id;

  vreg_data_t  mem [128];
  logic [31:0] stim_lfsr;
  logic [31:0] stall_lfsr;
  logic        stall_en;
  logic [1:0]  rgate;
  logic        wgate;
  vfu_id_t     next_id;
  int          ready_waits;
  int          test_num;
  int          failed_tests;
  int          err_base;
  logic        timed_out;
  string       timeout_what;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  vfu_top uut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .req_i          (req),
    .req_valid_i    (req_valid),
    .req_ready_o    (req_ready),
    .vrf_raddr_o    (vrf_raddr),
    .vrf_re_o       (vrf_re),
    .vrf_rdata_i    (vrf_rdata),
    .vrf_rvalid_i   (vrf_rvalid),
    .vrf_we_o       (vrf_we),
    .vrf_waddr_o    (vrf_waddr),
    .vrf_wdata_o    (vrf_wdata),
    .vrf_wvalid_i   (vrf_wvalid),
    .vfu_rsp_valid_o(rsp_valid),
    .vfu_rsp_id_o   (rsp_id)
  );

  vfu_checker chk (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_i       (req),
    .req_valid_i (req_valid),
    .req_ready_i (req_ready),
    .vrf_re_i    (vrf_re),
    .vrf_we_i    (vrf_we),
    .vrf_waddr_i (vrf_waddr),
    .vrf_wdata_i (vrf_wdata),
    .vrf_wvalid_i(vrf_wvalid),
    .rsp_valid_i (rsp_valid),
    .rsp_id_i    (rsp_id)
  );

  //////////////////////////////////////////////////
  // VRF model
  //////////////////////////////////////////////////

  assign vrf_rdata[0] = mem[vrf_raddr[0]];
  assign vrf_rdata[1] = mem[vrf_raddr[1]];
  assign vrf_rvalid   = vrf_re & rgate;
  assign vrf_wvalid   = wgate;

  always @(posedge clk) begin
    if (vrf_we && vrf_wvalid) begin
      mem[vrf_waddr] <= vrf_wdata;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      v = {v[62:0], stim_lfsr[0]};
    end
    return v;
  endfunction

  always @(negedge clk) begin
    if (stall_en) begin
      stall_lfsr = lfsr_next(stall_lfsr);
      rgate[0]   = stall_lfsr[0];
      stall_lfsr = lfsr_next(stall_lfsr);
      rgate[1]   = stall_lfsr[0];
      stall_lfsr = lfsr_next(stall_lfsr);
      wgate      = stall_lfsr[0];
    end else begin
      rgate = 2'b11;
      wgate = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Hands a stuck wait to the watchdog below
  task automatic flag_timeout(input string what);
    timeout_what = what;
    timed_out    = 1'b1;
  endtask

  initial begin
    wait (timed_out === 1'b1);
    $display("Timeout while waiting for %s", timeout_what);
    $display("Simulation finished: FAIL");
    $finish;
  end

  function automatic vfu_req_t make_req(input vfu_op_e op, input vew_e sew, input int vl,
                                        input int vd, input int vs1, input int vs2,
                                        input logic use_vs1, input logic [31:0] rs1);
    vfu_req_t r;
    r.id      = '0;
    r.op      = op;
    r.vsew    = sew;
    r.vl      = vlen_t'(vl);
    r.vd      = vreg_idx_t'(vd);
    r.vs1     = vreg_idx_t'(vs1);
    r.vs2     = vreg_idx_t'(vs2);
    r.use_vs1 = use_vs1;
    r.rs1     = rs1;
    return r;
  endfunction

  // Runs from a falling edge to the falling edge after the transfer
  task automatic send_req(input vfu_req_t r);
    int t;
    t         = 0;
    req       = r;
    req.id    = next_id;
    next_id   = next_id + vfu_id_t'(1);
    req_valid = 1'b1;
    while (!req_ready) begin
      @(negedge clk);
      t++;
      ready_waits++;
      if (t > REQ_TIMEOUT) flag_timeout("req_ready_o");
    end
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic wait_idle();
    int t;
    t = 0;
    while (chk.pending != 0) begin
      @(negedge clk);
      t++;
      if (t > IDLE_TIMEOUT) flag_timeout("the pending VRF writes");
    end
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = chk.errors - err_base;
    if (errs != 0) failed_tests++;
    test_num++;
    $display("Test %0d %s: %s, %0d errors", test_num, name,
             (errs == 0) ? "passed" : "failed", errs);
    err_base = chk.errors;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    vew_e sew;
    int   maxvl;
    int   vl;
    int   vd;
    int   vs1;
    int   vs2;
    logic use_vs1;
    logic [31:0] rs1;
    vfu_op_e op;

    rst_n        = 1'b0;
    req          = '0;
    req_valid    = 1'b0;
    stall_en     = 1'b0;
    rgate        = 2'b11;
    wgate        = 1'b1;
    stim_lfsr    = SEED;
    stall_lfsr   = SEED;
    next_id      = '0;
    ready_waits  = 0;
    test_num     = 0;
    failed_tests = 0;
    err_base     = 0;
    timed_out    = 1'b0;

    // Random fill with wrapping add and subtract patterns in vregs 3 and 4
    for (int a = 0; a < 128; a++) begin
      mem[a] = rand_bits(64);
      if (a / NR_WORDS_PER_VREG == 3) mem[a] = 64'hff7f_80ff_fffe_7f80 ^ 64'(a);
      if (a / NR_WORDS_PER_VREG == 4) mem[a] = 64'h01ff_8001_0003_8181 ^ 64'(a);
      chk.load_word(a, mem[a]);
    end

    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);

    chk.compare("req_ready_o", 64'(req_ready), 64'd1);
    chk.compare("vrf_re_o", 64'(vrf_re), 64'd0);
    chk.compare("vrf_we_o", 64'(vrf_we), 64'd0);
    chk.compare("vfu_rsp_valid_o", 64'(rsp_valid), 64'd0);
    finish_test("reset state");

    for (int k = 0; k < 7; k++) begin
      send_req(make_req(vfu_op_e'(3'(k)), EW_32, 8, 16 + k, 1, 2, 1'b1, 32'd0));
    end
    wait_idle();
    finish_test("all operations at SEW 32");

    send_req(make_req(VADD, EW_8, 13, 20, 4, 3, 1'b1, 32'd0));
    send_req(make_req(VSUB, EW_8, 5, 21, 4, 3, 1'b1, 32'd0));
    send_req(make_req(VADD, EW_16, 7, 22, 4, 3, 1'b1, 32'd0));
    send_req(make_req(VSUB, EW_16, 14, 23, 4, 3, 1'b1, 32'd0));
    wait_idle();
    finish_test("SEW 8 and 16 wrapping add and subtract");

    chk.scalar_only = 1'b1;
    send_req(make_req(VADD, EW_8, 32, 24, 5, 6, 1'b0, 32'(rand_bits(32))));
    send_req(make_req(VSUB, EW_16, 16, 25, 5, 6, 1'b0, 32'(rand_bits(32))));
    send_req(make_req(VMAXU, EW_32, 8, 26, 5, 6, 1'b0, 32'(rand_bits(32))));
    wait_idle();
    chk.scalar_only = 1'b0;
    finish_test("vector-scalar at each SEW");

    stall_en    = 1'b1;
    ready_waits = 0;
    for (int n = 0; n < N_RANDOM; n++) begin
      op      = vfu_op_e'(3'(rand_bits(3) % 7));
      sew     = vew_e'(2'(rand_bits(2) % 3));
      maxvl   = NR_WORDS_PER_VREG * (8 >> int'(sew));
      vl      = 1 + int'(rand_bits(5)) % maxvl;
      vd      = 16 + int'(rand_bits(4));
      vs1     = int'(rand_bits(4));
      vs2     = int'(rand_bits(4));
      use_vs1 = 1'(rand_bits(1));
      rs1     = 32'(rand_bits(32));
      send_req(make_req(op, sew, vl, vd, vs1, vs2, use_vs1, rs1));
    end
    wait_idle();
    chk.expect_true(ready_waits != 0, "req_ready_o never fell under back-pressure");
    stall_en = 1'b0;
    finish_test("random requests with stalls");

    // Quiet cycles catch stray writes or responses
    repeat (10) @(negedge clk);
    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             test_num, failed_tests, chk.checks, chk.errors);
    if (chk.errors == 0 && failed_tests == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== bench/vfu_checker.sv ====
`timescale 1ns/1ps
// Watches the DUT ports and compares every VRF write and response in order
// Expected words are taken from a shadow VRF when a request is accepted
// Source registers must not be written by any instruction still in flight

module vfu_checker (
  input logic                clk_i,
  input logic                rst_n_i,
  input vfu_pkg::vfu_req_t   req_i,
  input logic                req_valid_i,
  input logic                req_ready_i,
  input logic          [1:0] vrf_re_i,
  input logic                vrf_we_i,
  input vfu_pkg::vreg_addr_t vrf_waddr_i,
  input vfu_pkg::vreg_data_t vrf_wdata_i,
  input logic                vrf_wvalid_i,
  input logic                rsp_valid_i,
  input vfu_pkg::vfu_id_t    rsp_id_i
);

  import vfu_pkg::*;

  vreg_data_t shadow [128];
  vfu_wb_t    exp_q[$];
  vfu_wb_t    head;
  int         errors = 0;
  int         checks = 0;
  int         pending = 0;
  logic       scalar_only = 1'b0;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // One VRF word, element by element, op2 is the vs2 operand
  function automatic vreg_data_t ref_word(input vfu_op_e op, input vew_e sew,
                                          input vreg_data_t op1, input vreg_data_t op2);
    int              ew;
    longint unsigned mask;
    longint unsigned x;
    longint unsigned y;
    longint unsigned r;
    vreg_data_t      res;
    ew   = 8 << int'(sew);
    mask = (64'd1 << ew) - 64'd1;
    res  = '0;
    for (int e = 0; e < VRF_DATA_W / ew; e++) begin
      x = (op1 >> (e * ew)) & mask;
      y = (op2 >> (e * ew)) & mask;
      case (op)
        VADD:    r = y + x;
        VSUB:    r = y - x;
        VAND:    r = y & x;
        VOR:     r = y | x;
        VXOR:    r = y ^ x;
        VMINU:   r = (y < x) ? y : x;
        VMAXU:   r = (y > x) ? y : x;
        default: r = 0;
      endcase
      res = res | vreg_data_t'((r & mask) << (e * ew));
    end
    return res;
  endfunction

  function automatic vreg_data_t replicate(input logic [31:0] s, input vew_e sew);
    int              ew;
    longint unsigned mask;
    vreg_data_t      res;
    ew   = 8 << int'(sew);
    mask = (64'd1 << ew) - 64'd1;
    res  = '0;
    for (int e = 0; e < VRF_DATA_W / ew; e++) begin
      res = res | vreg_data_t'((64'(s) & mask) << (e * ew));
    end
    return res;
  endfunction

  function automatic vreg_addr_t addr_of(input vreg_idx_t vreg, input int word);
    return vreg_addr_t'(int'(vreg) * NR_WORDS_PER_VREG + word);
  endfunction

  //////////////////////////////////////////////////
  // Checks and counts
  //////////////////////////////////////////////////

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error %s: expected 0x%0h, got 0x%0h", name, exp, got);
    end
  endtask

  task automatic expect_true(input logic ok, input string what);
    checks++;
    if (!ok) begin
      errors++;
      $display("%s", what);
    end
  endtask

  task automatic load_word(input int addr, input vreg_data_t data);
    shadow[addr] = data;
  endtask

  task automatic push_request(input vfu_req_t r);
    int         epw;
    int         nwords;
    vreg_data_t op1;
    vfu_wb_t    item;
    epw    = 8 >> int'(r.vsew);
    nwords = (int'(r.vl) + epw - 1) / epw;
    for (int w = 0; w < nwords; w++) begin
      op1        = r.use_vs1 ? shadow[addr_of(r.vs1, w)] : replicate(r.rs1, r.vsew);
      item.waddr = addr_of(r.vd, w);
      item.wdata = ref_word(r.op, r.vsew, op1, shadow[addr_of(r.vs2, w)]);
      item.id    = r.id;
      item.last  = (w == nwords - 1);
      exp_q.push_back(item);
    end
  endtask

  task automatic check_write();
    if (exp_q.size() == 0) begin
      expect_true(1'b0, $sformatf("Write to address 0x%0h with no word pending", vrf_waddr_i));
    end else begin
      head = exp_q.pop_front();
      compare("vrf_waddr_o", 64'(vrf_waddr_i), 64'(head.waddr));
      compare("vrf_wdata_o", vrf_wdata_i, head.wdata);
      if (head.last) begin
        expect_true(rsp_valid_i, "No response in the cycle of the last word");
        if (rsp_valid_i) begin
          compare("vfu_rsp_id_o", 64'(rsp_id_i), 64'(head.id));
        end
      end else begin
        expect_true(!rsp_valid_i, "Response given before the last word");
      end
    end
    shadow[vrf_waddr_i] = vrf_wdata_i;
  endtask

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (req_valid_i && req_ready_i) begin
        push_request(req_i);
      end
      if (vrf_we_i && vrf_wvalid_i) begin
        check_write();
      end else if (rsp_valid_i) begin
        expect_true(1'b0, "Response without an accepted write");
      end
      if (scalar_only && vrf_re_i[1]) begin
        expect_true(1'b0, "vs1 read issued for a vector-scalar instruction");
      end
      pending = exp_q.size();
    end
  end

endmodule

// ==== sim.f ====
source/vfu_pkg.sv
source/vfu_spill_reg.sv
source/vfu_lane.sv
source/vfu_controller.sv
source/vfu_writeback.sv
source/vfu_top.sv
bench/vfu_checker.sv
bench/tb_top.sv

// ==== source/vfu_controller.sv ====
`timescale 1ns/1ps
// Sequences the head instruction of the request queue word by word
// Reads vs2 on port 0 and vs1 on port 1 with one VRF word per cycle
// Issues a word only when all needed reads are valid and the result stage is ready
// Popping the queue on the last word lets the next instruction follow directly

module vfu_controller (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // Head of the request queue
  input  vfu_pkg::vfu_req_t          req_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  // VRF read port
  output vfu_pkg::vreg_addr_t  [1:0] vrf_raddr_o,
  output logic                 [1:0] vrf_re_o,
  input  vfu_pkg::vreg_data_t  [1:0] vrf_rdata_i,
  input  logic                 [1:0] vrf_rvalid_i,
  // Lanes
  output vfu_pkg::vreg_data_t        lane_op1_o,
  output vfu_pkg::vreg_data_t        lane_op2_o,
  output vfu_pkg::vfu_op_e           lane_op_o,
  output vfu_pkg::vew_e              lane_sew_o,
  input  vfu_pkg::vreg_data_t        lane_result_i,
  // Result stage
  output vfu_pkg::vfu_wb_t           wb_o,
  output logic                       wb_valid_o,
  input  logic                       wb_ready_i
);

  import vfu_pkg::*;

  //////////////////////////////////////////////////
  // Element and word counting
  //////////////////////////////////////////////////

  vlen_t                  elem_cnt_q;
  word_idx_t              word_q;
  vlen_t                  epw;
  logic [$bits(vlen_t):0] next_cnt;
  logic                   last_word;
  logic                   operands_valid;
  logic                   issue;

  // Elements per VRF word at the current SEW
  assign epw       = vlen_t'(NR_BYTES_PER_WORD >> req_i.vsew);
  assign next_cnt  = {1'b0, elem_cnt_q} + {1'b0, epw};
  assign last_word = next_cnt >= {1'b0, req_i.vl};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      elem_cnt_q <= '0;
      word_q     <= '0;
    end else if (issue) begin
      if (last_word) begin
        elem_cnt_q <= '0;
        word_q     <= '0;
      end else begin
        elem_cnt_q <= next_cnt[$bits(vlen_t)-1:0];
        word_q     <= word_q + word_idx_t'(1);
      end
    end
  end

  //////////////////////////////////////////////////
  // Operand requests
  //////////////////////////////////////////////////

  // Address stays put until the word issues
  assign vrf_raddr_o[0] = {req_i.vs2, word_q};
  assign vrf_raddr_o[1] = {req_i.vs1, word_q};
  assign vrf_re_o       = {req_valid_i && req_i.use_vs1, req_valid_i};

  assign operands_valid = req_valid_i && vrf_rvalid_i[0] &&
                          (!req_i.use_vs1 || vrf_rvalid_i[1]);

  // Scalar operand replicated to the element width
  always_comb begin
    if (req_i.use_vs1) begin
      lane_op1_o = vrf_rdata_i[1];
    end else begin
      unique case (req_i.vsew)
        EW_8:    lane_op1_o = {(VRF_DATA_W / 8){req_i.rs1[7:0]}};
        EW_16:   lane_op1_o = {(VRF_DATA_W / 16){req_i.rs1[15:0]}};
        default: lane_op1_o = {(VRF_DATA_W / 32){req_i.rs1}};
      endcase
    end
  end

  assign lane_op2_o = vrf_rdata_i[0];
  assign lane_op_o  = req_i.op;
  assign lane_sew_o = req_i.vsew;

  //////////////////////////////////////////////////
  // Issue
  //////////////////////////////////////////////////

  assign wb_valid_o  = operands_valid;
  assign issue       = wb_valid_o && wb_ready_i;
  assign req_ready_o = issue && last_word;

  always_comb begin
    wb_o.waddr = {req_i.vd, word_q};
    wb_o.wdata = lane_result_i;
    wb_o.id    = req_i.id;
    wb_o.last  = last_word;
  end

  vl_nonzero_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i |-> (req_i.vl != '0));

endmodule

// ==== source/vfu_lane.sv ====
`timescale 1ns/1ps
// One 32-bit SIMD integer ALU, purely combinational
// Elements are independent, no carry or borrow crosses an element boundary
// Subtract is op2 - op1, min and max compare unsigned

module vfu_lane (
  input  vfu_pkg::vfu_op_e         op_i,
  input  vfu_pkg::vew_e            sew_i,
  input  logic [vfu_pkg::ELEN-1:0] op1_i,
  input  logic [vfu_pkg::ELEN-1:0] op2_i,
  output logic [vfu_pkg::ELEN-1:0] result_o
);

  import vfu_pkg::*;

  // Works on zero-extended elements, the caller keeps the low bits
  function automatic logic [ELEN-1:0] elem_alu(
    input vfu_op_e         op,
    input logic [ELEN-1:0] a,
    input logic [ELEN-1:0] b
  );
    logic [ELEN-1:0] res;
    unique case (op)
      VADD:    res = b + a;
      VSUB:    res = b - a;
      VAND:    res = b & a;
      VOR:     res = b | a;
      VXOR:    res = b ^ a;
      VMINU:   res = (b < a) ? b : a;
      VMAXU:   res = (b > a) ? b : a;
      default: res = '0;
    endcase
    return res;
  endfunction

  logic [ELEN-1:0] res8, res16, res32;

  always_comb begin
    for (int e = 0; e < ELEN / 8; e++) begin
      res8[8*e +: 8] = 8'(elem_alu(op_i, ELEN'(op1_i[8*e +: 8]), ELEN'(op2_i[8*e +: 8])));
    end
    for (int e = 0; e < ELEN / 16; e++) begin
      res16[16*e +: 16] = 16'(elem_alu(op_i, ELEN'(op1_i[16*e +: 16]),
                                       ELEN'(op2_i[16*e +: 16])));
    end
    res32 = elem_alu(op_i, op1_i, op2_i);
  end

  // Pick the result of the active element width
  always_comb begin
    unique case (sew_i)
      EW_8:    result_o = res8;
      EW_16:   result_o = res16;
      default: result_o = res32;
    endcase
  end

endmodule

// ==== source/vfu_pkg.sv ====
// Shared types and constants of the vector execution unit
// A vector register holds NR_WORDS_PER_VREG words of VRF_DATA_W bits
// NR_WORDS_PER_VREG must be a power of two, word addresses are {vreg, word}
// Element counts are limited to one vector register (vl <= 32 at SEW 8)

package vfu_pkg;

  //////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////

  localparam int unsigned N_LANES           = 2;
  localparam int unsigned ELEN              = 32;
  localparam int unsigned VRF_DATA_W        = N_LANES * ELEN;
  localparam int unsigned NR_BYTES_PER_WORD = VRF_DATA_W / 8;
  localparam int unsigned NR_WORDS_PER_VREG = 4;
  localparam int unsigned NR_VREGS          = 32;
  localparam int unsigned WORD_IDX_W        = $clog2(NR_WORDS_PER_VREG);
  localparam int unsigned VREG_IDX_W        = $clog2(NR_VREGS);

  typedef logic [VREG_IDX_W-1:0]            vreg_idx_t;
  typedef logic [WORD_IDX_W-1:0]            word_idx_t;
  typedef logic [VREG_IDX_W+WORD_IDX_W-1:0] vreg_addr_t;
  typedef logic [VRF_DATA_W-1:0]            vreg_data_t;
  typedef logic [5:0]                       vlen_t;
  typedef logic [1:0]                       vfu_id_t;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vew_e;

  typedef enum logic [2:0] {
    VADD,
    VSUB,
    VAND,
    VOR,
    VXOR,
    VMINU,
    VMAXU
  } vfu_op_e;

  // Instruction as it enters the unit
  typedef struct packed {
    vfu_id_t     id;
    vfu_op_e     op;
    vew_e        vsew;
    vlen_t       vl;
    vreg_idx_t   vd;
    vreg_idx_t   vs1;
    vreg_idx_t   vs2;
    logic        use_vs1;
    logic [31:0] rs1;
  } vfu_req_t;

  // One result word on its way to the VRF
  typedef struct packed {
    vreg_addr_t waddr;
    vreg_data_t wdata;
    vfu_id_t    id;
    logic       last;
  } vfu_wb_t;

endpackage

// ==== source/vfu_spill_reg.sv ====
`timescale 1ns/1ps
// Two-slot register, cuts both the valid and the ready path
// Full throughput while the consumer keeps ready_i high
// Output data is held stable until it is taken

module vfu_spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // Slot A takes new data, slot B keeps what the output refused
  logic a_full_q, b_full_q;
  T     a_data_q, b_data_q;
  logic a_fill, a_drain, b_fill, b_drain;

  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill || (a_full_q && !a_drain);
      b_full_q <= b_fill || (b_full_q && !b_drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // B is always the older entry
  assign ready_o = !a_full_q || !b_full_q;
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  data_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(data_o)));

endmodule

// ==== source/vfu_top.sv ====
`timescale 1ns/1ps
// Integer vector execution unit on an external VRF
// Read port 0 carries vs2, read port 1 carries vs1
// Words and responses leave in request order

module vfu_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  vfu_pkg::vfu_req_t         req_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  output vfu_pkg::vreg_addr_t [1:0] vrf_raddr_o,
  output logic                [1:0] vrf_re_o,
  input  vfu_pkg::vreg_data_t [1:0] vrf_rdata_i,
  input  logic                [1:0] vrf_rvalid_i,
  output logic                      vrf_we_o,
  output vfu_pkg::vreg_addr_t       vrf_waddr_o,
  output vfu_pkg::vreg_data_t       vrf_wdata_o,
  input  logic                      vrf_wvalid_i,
  output logic                      vfu_rsp_valid_o,
  output vfu_pkg::vfu_id_t          vfu_rsp_id_o
);

  import vfu_pkg::*;

  vfu_req_t   q_req;
  logic       q_valid, q_ready;
  vreg_data_t lane_op1, lane_op2, lane_result;
  vfu_op_e    lane_op;
  vew_e       lane_sew;
  vfu_wb_t    wb;
  logic       wb_valid, wb_ready;

  //////////////////////////////////////////////////
  // Request queue
  //////////////////////////////////////////////////

  vfu_spill_reg #(
    .T(vfu_req_t)
  ) i_req_queue (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(req_valid_i),
    .ready_o(req_ready_o),
    .data_i (req_i),
    .valid_o(q_valid),
    .ready_i(q_ready),
    .data_o (q_req)
  );

  vfu_controller i_controller (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (q_req),
    .req_valid_i  (q_valid),
    .req_ready_o  (q_ready),
    .vrf_raddr_o  (vrf_raddr_o),
    .vrf_re_o     (vrf_re_o),
    .vrf_rdata_i  (vrf_rdata_i),
    .vrf_rvalid_i (vrf_rvalid_i),
    .lane_op1_o   (lane_op1),
    .lane_op2_o   (lane_op2),
    .lane_op_o    (lane_op),
    .lane_sew_o   (lane_sew),
    .lane_result_i(lane_result),
    .wb_o         (wb),
    .wb_valid_o   (wb_valid),
    .wb_ready_i   (wb_ready)
  );

  //////////////////////////////////////////////////
  // Lanes
  //////////////////////////////////////////////////

  for (genvar l = 0; l < N_LANES; l++) begin : gen_lanes
    vfu_lane i_lane (
      .op_i    (lane_op),
      .sew_i   (lane_sew),
      .op1_i   (lane_op1[l*ELEN +: ELEN]),
      .op2_i   (lane_op2[l*ELEN +: ELEN]),
      .result_o(lane_result[l*ELEN +: ELEN])
    );
  end

  vfu_writeback i_writeback (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wb_i        (wb),
    .wb_valid_i  (wb_valid),
    .wb_ready_o  (wb_ready),
    .vrf_we_o    (vrf_we_o),
    .vrf_waddr_o (vrf_waddr_o),
    .vrf_wdata_o (vrf_wdata_o),
    .vrf_wvalid_i(vrf_wvalid_i),
    .rsp_valid_o (vfu_rsp_valid_o),
    .rsp_id_o    (vfu_rsp_id_o)
  );

endmodule

// ==== source/vfu_writeback.sv ====
`timescale 1ns/1ps
// Result stage in front of the VRF write port
// A word is written when we and wvalid are high together
// The response pulses in the cycle the last word of an instruction is written

module vfu_writeback (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  vfu_pkg::vfu_wb_t    wb_i,
  input  logic                wb_valid_i,
  output logic                wb_ready_o,
  output logic                vrf_we_o,
  output vfu_pkg::vreg_addr_t vrf_waddr_o,
  output vfu_pkg::vreg_data_t vrf_wdata_o,
  input  logic                vrf_wvalid_i,
  output logic                rsp_valid_o,
  output vfu_pkg::vfu_id_t    rsp_id_o
);

  import vfu_pkg::*;

  vfu_wb_t staged;
  logic    staged_valid;

  vfu_spill_reg #(
    .T(vfu_wb_t)
  ) i_result_stage (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(wb_valid_i),
    .ready_o(wb_ready_o),
    .data_i (wb_i),
    .valid_o(staged_valid),
    .ready_i(vrf_wvalid_i),
    .data_o (staged)
  );

  assign vrf_we_o    = staged_valid;
  assign vrf_waddr_o = staged.waddr;
  assign vrf_wdata_o = staged.wdata;

  // Completion on acceptance of the final word
  assign rsp_valid_o = staged_valid && vrf_wvalid_i && staged.last;
  assign rsp_id_o    = staged.id;

endmodule
